// ==== lsu_aw_issue.sv ====
`timescale 1ns/1ns

module lsu_aw_issue (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    aw_start,
    input  lsu_cmd_pkg::dram_addr_t dram_addr,
    input  lsu_cmd_pkg::num_t       num,
    input  lsu_cmd_pkg::len_code_t  len,
    input  lsu_cmd_pkg::str_t       str,
    input  logic                    awrdy,
    output logic                    awvld,
    output lsu_mem_pkg::aw_addr_t   awaddr,
    output lsu_cmd_pkg::num_t       awlen,
    output lsu_cmd_pkg::len_code_t  awsize,
    output lsu_cmd_pkg::str_t       awstr,
    output lsu_mem_pkg::aw_num_t    awnum,
    output logic                    aw_done
);
    import lsu_mem_pkg::*;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            awvld   <= 1'b0;
            aw_done <= 1'b0;
        end else begin
            aw_done <= awvld && awrdy;
            if (aw_start) begin
                awvld <= 1'b1;
            end else if (awvld && awrdy) begin
                awvld <= 1'b0;
            end
        end
    end

    // request fields, held until the slave takes them
    always_ff @(posedge clk) begin
        if (aw_start) begin
            awaddr <= dram_addr[13:4];
            awlen  <= num;
            awsize <= len;
            awstr  <= str;
            // beats needed to move one 16-byte row
            awnum  <= aw_num_t'(ROW_BYTES >> len);
        end
    end

    // request must hold under back-pressure
    a_aw_stable: assert property (@(posedge clk) disable iff (!rst_n)
        awvld && !awrdy |=> awvld && $stable(awaddr) && $stable(awlen) &&
                            $stable(awsize) && $stable(awstr) && $stable(awnum));

endmodule

// ==== lsu_cmd_pkg.sv ====
package lsu_cmd_pkg;

    // largest element length code for sram stores, 2^4 = 16 bytes
    localparam int MAX_LEN_CODE = 4;

    localparam int ROW_IDX_W  = 4;
    localparam int NUM_W      = 8;
    localparam int LEN_W      = 3;
    localparam int STR_W      = 3;
    localparam int LDST_W     = 12;
    localparam int DRAM_W     = 31;

    // store target, same encoding as the decode unit uses
    typedef enum logic [1:0] {
        ST_IRAM = 2'd0,
        ST_WRAM = 2'd1,
        ST_ORAM = 2'd2,
        ST_DRAM = 2'd3
    } st_target_e;

    // instruction fields
    typedef logic [ROW_IDX_W-1:0] row_idx_t;
    typedef logic [ROW_IDX_W-1:0] col_idx_t;
    typedef logic [NUM_W-1:0]     num_t;
    typedef logic [LEN_W-1:0]     len_code_t;
    typedef logic [STR_W-1:0]     str_t;
    typedef logic [LDST_W-1:0]    ld_st_addr_t;
    typedef logic [DRAM_W-1:0]    dram_addr_t;

endpackage

// ==== lsu_mem_pkg.sv ====
package lsu_mem_pkg;

    // matrix unit result array
    localparam int MXU_ROWS  = 16;
    localparam int ROW_BYTES = 16;
    localparam int ROW_BITS  = ROW_BYTES * 8;

    // sram row address width, one address per 16-byte row
    localparam int SRAM_ADDR_W = 8;

    // aw channel widths
    localparam int AW_ADDR_W = 10;
    localparam int AW_NUM_W  = 5;

    typedef logic [ROW_BITS-1:0] row_data_t;

    // row 0 sits in the low bits
    typedef row_data_t [MXU_ROWS-1:0] mxu_rows_t;

    typedef logic [ROW_BYTES-1:0] byte_en_t;

    typedef logic [SRAM_ADDR_W-1:0] sram_addr_t;

    // dram 16-byte line index
    typedef logic [AW_ADDR_W-1:0] aw_addr_t;

    // beats per row
    typedef logic [AW_NUM_W-1:0] aw_num_t;

endpackage

// ==== lsu_row_counter.sv ====
`timescale 1ns/1ns

module lsu_row_counter (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     accept,
    input  logic                     write_en,
    input  lsu_cmd_pkg::row_idx_t    start_y,
    input  lsu_cmd_pkg::num_t        num,
    input  lsu_cmd_pkg::ld_st_addr_t ld_st_addr,
    output lsu_cmd_pkg::row_idx_t    row_sel,
    output lsu_mem_pkg::sram_addr_t  row_addr,
    output logic                     last
);
    import lsu_cmd_pkg::*;
    import lsu_mem_pkg::*;

    row_idx_t   row_q;
    sram_addr_t addr_q;
    // rows still to be written, including the current one
    num_t       remaining;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_q     <= '0;
            addr_q    <= '0;
            remaining <= '0;
        end else if (accept) begin
            row_q     <= start_y;
            // sram is addressed per 16-byte row
            addr_q    <= ld_st_addr[11:4];
            remaining <= num;
        end else if (write_en) begin
            row_q     <= row_idx_t'(row_q + 1'b1);
            addr_q    <= sram_addr_t'(addr_q + 1'b1);
            remaining <= num_t'(remaining - 1'b1);
        end
    end

    assign row_sel  = row_q;
    assign row_addr = addr_q;
    assign last     = (remaining == num_t'(1));

    // fields latched at acceptance must describe a store inside the matrix
    a_rows_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(write_en) |-> (remaining != '0) &&
                            (int'(row_q) + int'(remaining) <= MXU_ROWS));

endmodule

// ==== lsu_row_packer.sv ====
`timescale 1ns/1ns

module lsu_row_packer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    accept,
    input  logic                    write_en,
    input  lsu_cmd_pkg::st_target_e target,
    input  lsu_cmd_pkg::col_idx_t   start_x,
    input  lsu_cmd_pkg::len_code_t  len,
    input  lsu_cmd_pkg::row_idx_t   row_sel,
    input  lsu_mem_pkg::sram_addr_t row_addr,
    input  lsu_mem_pkg::mxu_rows_t  mxu_rows,
    output logic                    iram_we,
    output logic                    wram_we,
    output logic                    oram_we,
    output lsu_mem_pkg::sram_addr_t sram_addr,
    output lsu_mem_pkg::row_data_t  sram_din,
    output lsu_mem_pkg::byte_en_t   sram_be
);
    import lsu_cmd_pkg::*;
    import lsu_mem_pkg::*;

    col_idx_t    start_x_q;
    len_code_t   len_q;
    // 2^len ones, before the shift to start_x
    logic [31:0] win_bits;
    byte_en_t    be;
    row_data_t   bit_mask;

    always_ff @(posedge clk) begin
        if (accept) begin
            start_x_q <= start_x;
            len_q     <= len;
        end
    end

    assign win_bits = (32'd1 << (32'd1 << len_q)) - 32'd1;
    assign be       = byte_en_t'(win_bits << start_x_q);

    // widen byte enables to a bit mask
    always_comb begin
        for (int b = 0; b < ROW_BYTES; b++) begin
            bit_mask[b*8 +: 8] = {8{be[b]}};
        end
    end

    // one strobe per target, sram write port is shared
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            iram_we <= 1'b0;
            wram_we <= 1'b0;
            oram_we <= 1'b0;
        end else begin
            iram_we <= write_en && (target == ST_IRAM);
            wram_we <= write_en && (target == ST_WRAM);
            oram_we <= write_en && (target == ST_ORAM);
        end
    end

    always_ff @(posedge clk) begin
        if (write_en) begin
            sram_addr <= row_addr;
            sram_din  <= mxu_rows[row_sel] & bit_mask;
            sram_be   <= be;
        end
    end

    // window latched at acceptance has to fit in one row
    a_window_in_row: assert property (@(posedge clk) disable iff (!rst_n)
        write_en |-> (int'(len_q) <= MAX_LEN_CODE) &&
                     (int'(start_x_q) + (1 << len_q) <= ROW_BYTES));

endmodule

// ==== lsu_store_fsm.sv ====
`timescale 1ns/1ns

module lsu_store_fsm (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    vld,
    input  logic                    st_iram,
    input  logic                    st_wram,
    input  logic                    st_oram,
    input  logic                    st_dram,
    input  logic                    mxu_data_rdy,
    input  logic                    last,
    input  logic                    aw_done,
    output logic                    rdy,
    output logic                    accept,
    output lsu_cmd_pkg::st_target_e target,
    output logic                    write_en,
    output logic                    aw_start
);
    import lsu_cmd_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_MXU,
        WRITE,
        ISSUE_AW
    } state_e;

    state_e     state;
    state_e     state_nxt;
    st_target_e target_nxt;
    logic       sram_st;
    // high while the packer still presents the final row
    logic       drain;

    assign sram_st  = st_iram | st_wram | st_oram;
    assign rdy      = (state == IDLE) && !drain;
    assign accept   = vld && rdy;
    assign write_en = (state == WRITE);

    // sram flags win over dram
    assign aw_start = accept && st_dram && !sram_st;

    // priority iram > wram > oram > dram
    always_comb begin
        if (st_iram) begin
            target_nxt = ST_IRAM;
        end else if (st_wram) begin
            target_nxt = ST_WRAM;
        end else if (st_oram) begin
            target_nxt = ST_ORAM;
        end else begin
            target_nxt = ST_DRAM;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (accept && sram_st) begin
                    state_nxt = WAIT_MXU;
                end else if (aw_start) begin
                    state_nxt = ISSUE_AW;
                end
            end
            // data-ready level only looked at here
            WAIT_MXU: begin
                if (mxu_data_rdy) begin
                    state_nxt = WRITE;
                end
            end
            WRITE: begin
                if (last) begin
                    state_nxt = IDLE;
                end
            end
            ISSUE_AW: begin
                if (aw_done) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= IDLE;
            target <= ST_IRAM;
            drain  <= 1'b0;
        end else begin
            state <= state_nxt;
            drain <= write_en && last;
            if (accept) begin
                target <= target_nxt;
            end
        end
    end

    // aw completion only arrives while the request is pending, never during row writes
    a_aw_done_in_issue: assert property (@(posedge clk) disable iff (!rst_n)
        aw_done |-> (state == ISSUE_AW));

endmodule

// ==== lsu_top.sv ====
`timescale 1ns/1ns

module lsu_top (
    input  logic                     clk,
    input  logic                     rst_n,
    // decode unit
    input  logic                     vld,
    input  logic                     st_iram,
    input  logic                     st_wram,
    input  logic                     st_oram,
    input  logic                     st_dram,
    input  lsu_cmd_pkg::dram_addr_t  dram_addr,
    input  lsu_cmd_pkg::num_t        num,
    input  lsu_cmd_pkg::len_code_t   len,
    input  lsu_cmd_pkg::str_t        str,
    input  lsu_cmd_pkg::col_idx_t    start_x,
    input  lsu_cmd_pkg::row_idx_t    start_y,
    input  lsu_cmd_pkg::ld_st_addr_t ld_st_addr,
    output logic                     rdy,
    // matrix unit
    input  lsu_mem_pkg::mxu_rows_t   mxu_rows,
    input  logic                     mxu_data_rdy,
    // sram write port
    output logic                     iram_we,
    output logic                     wram_we,
    output logic                     oram_we,
    output lsu_mem_pkg::sram_addr_t  sram_addr,
    output lsu_mem_pkg::row_data_t   sram_din,
    output lsu_mem_pkg::byte_en_t    sram_be,
    // axi write address
    output logic                     awvld,
    output lsu_mem_pkg::aw_addr_t    awaddr,
    output lsu_cmd_pkg::num_t        awlen,
    output lsu_cmd_pkg::len_code_t   awsize,
    output lsu_cmd_pkg::str_t        awstr,
    output lsu_mem_pkg::aw_num_t     awnum,
    input  logic                     awrdy
);
    import lsu_cmd_pkg::*;
    import lsu_mem_pkg::*;

    logic       accept;
    st_target_e target;
    logic       write_en;
    logic       aw_start;
    logic       aw_done;
    row_idx_t   row_sel;
    sram_addr_t row_addr;
    logic       last;

    lsu_store_fsm fsm_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .vld          (vld),
        .st_iram      (st_iram),
        .st_wram      (st_wram),
        .st_oram      (st_oram),
        .st_dram      (st_dram),
        .mxu_data_rdy (mxu_data_rdy),
        .last         (last),
        .aw_done      (aw_done),
        .rdy          (rdy),
        .accept       (accept),
        .target       (target),
        .write_en     (write_en),
        .aw_start     (aw_start)
    );

    lsu_row_counter row_cnt_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .accept     (accept),
        .write_en   (write_en),
        .start_y    (start_y),
        .num        (num),
        .ld_st_addr (ld_st_addr),
        .row_sel    (row_sel),
        .row_addr   (row_addr),
        .last       (last)
    );

    lsu_row_packer packer_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .accept    (accept),
        .write_en  (write_en),
        .target    (target),
        .start_x   (start_x),
        .len       (len),
        .row_sel   (row_sel),
        .row_addr  (row_addr),
        .mxu_rows  (mxu_rows),
        .iram_we   (iram_we),
        .wram_we   (wram_we),
        .oram_we   (oram_we),
        .sram_addr (sram_addr),
        .sram_din  (sram_din),
        .sram_be   (sram_be)
    );

    lsu_aw_issue aw_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .aw_start  (aw_start),
        .dram_addr (dram_addr),
        .num       (num),
        .len       (len),
        .str       (str),
        .awrdy     (awrdy),
        .awvld     (awvld),
        .awaddr    (awaddr),
        .awlen     (awlen),
        .awsize    (awsize),
        .awstr     (awstr),
        .awnum     (awnum),
        .aw_done   (aw_done)
    );

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the lsu testbench with verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

if ! verilator --binary --timing --assert -j 0 -f sim.f --top-module tb_lsu -o Vtb_lsu; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/Vtb_lsu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: PASS" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== sim.f ====
lsu_cmd_pkg.sv
lsu_mem_pkg.sv
lsu_store_fsm.sv
lsu_row_counter.sv
lsu_row_packer.sv
lsu_aw_issue.sv
lsu_top.sv
tb_lsu.sv

// ==== tb_lsu.sv ====
`timescale 1ns/1ns

module tb_lsu;
    import lsu_cmd_pkg::*;
    import lsu_mem_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int RST_CYCLES = 5;
    // worst case per test: reset check, iram, wram wait, oram, dram, back-to-back
    localparam int TEST_CYCLES = 4 + 10 + 20 + 12 + 16 + 24;
    localparam int WATCHDOG_NS = 2 * (RST_CYCLES + TEST_CYCLES) * CLK_PERIOD;

    logic        clk;
    logic        rst_n;
    logic        vld;
    logic        rdy;
    logic        st_iram, st_wram, st_oram, st_dram;
    dram_addr_t  dram_addr;
    num_t        num;
    len_code_t   len;
    str_t        str;
    col_idx_t    start_x;
    row_idx_t    start_y;
    ld_st_addr_t ld_st_addr;
    mxu_rows_t   mxu_rows;
    logic        mxu_data_rdy;
    logic        iram_we, wram_we, oram_we;
    sram_addr_t  sram_addr;
    row_data_t   sram_din;
    byte_en_t    sram_be;
    logic        awvld;
    aw_addr_t    awaddr;
    num_t        awlen;
    len_code_t   awsize;
    str_t        awstr;
    aw_num_t     awnum;
    logic        awrdy;

    int          cycle = 0;
    int          errors = 0;
    int          aw_count = 0;
    logic [31:0] lcg_state = 32'd67205;

    // observed sram writes, strobes as {iram, wram, oram}
    logic [2:0]  wr_we[$];
    sram_addr_t  wr_addr[$];
    row_data_t   wr_din[$];
    byte_en_t    wr_be[$];
    int          wr_cycle[$];

    lsu_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // outputs change on the rising edge, so sample them mid-cycle
    always @(negedge clk) begin
        if (iram_we || wram_we || oram_we) begin
            wr_we.push_back({iram_we, wram_we, oram_we});
            wr_addr.push_back(sram_addr);
            wr_din.push_back(sram_din);
            wr_be.push_back(sram_be);
            wr_cycle.push_back(cycle);
        end
        if (awvld) begin
            aw_count++;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic check(input string name, input logic [127:0] actual,
                         input logic [127:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("RESULT: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic fill_matrix();
        logic [MXU_ROWS*ROW_BITS-1:0] flat;
        for (int w = 0; w < MXU_ROWS * ROW_BITS / 32; w++) begin
            flat[w*32 +: 32] = next_rand();
        end
        mxu_rows <= flat;
    endtask

    // called just after a rising edge
    task automatic drive_cmd(input logic [3:0] flags, input row_idx_t sy, input num_t n,
                             input col_idx_t sx, input len_code_t ln,
                             input logic [30:0] addr, input str_t st);
        vld        <= 1'b1;
        {st_dram, st_oram, st_wram, st_iram} <= flags;
        start_y    <= sy;
        num        <= n;
        start_x    <= sx;
        len        <= ln;
        ld_st_addr <= addr[11:0];
        dram_addr  <= addr;
        str        <= st;
    endtask

    task automatic drive_idle();
        vld <= 1'b0;
        {st_dram, st_oram, st_wram, st_iram} <= 4'b0000;
    endtask

    // returns the cycle number of the accepting edge, just after that edge
    task automatic wait_accept(output int acc);
        @(negedge clk);
        while (!rdy) @(negedge clk);
        acc = cycle + 1;
        @(posedge clk);
    endtask

    task automatic wait_rdy(output int at_cycle);
        @(negedge clk);
        while (!rdy) @(negedge clk);
        at_cycle = cycle;
        @(posedge clk);
    endtask

    // expected rows start_y onward, masked to the byte window
    task automatic check_sram(input logic [2:0] we_exp, input int base, input row_idx_t sy,
                              input num_t n, input col_idx_t sx, input len_code_t ln,
                              input ld_st_addr_t la, input int first);
        row_data_t  row;
        row_data_t  exp_din;
        byte_en_t   exp_be;
        sram_addr_t exp_addr;
        int         width;
        logic       in_win;
        width = 1 << ln;
        for (int k = 0; k < int'(n); k++) begin
            row      = mxu_rows[row_idx_t'(int'(sy) + k)];
            exp_addr = sram_addr_t'(int'(la[11:4]) + k);
            for (int b = 0; b < ROW_BYTES; b++) begin
                in_win              = (b >= int'(sx)) && (b < int'(sx) + width);
                exp_be[b]           = in_win;
                exp_din[b*8 +: 8]   = in_win ? row[b*8 +: 8] : 8'h00;
            end
            check("write strobes", 128'(wr_we[base + k]), 128'(we_exp));
            check("sram_addr", 128'(wr_addr[base + k]), 128'(exp_addr));
            check("sram_be", 128'(wr_be[base + k]), 128'(exp_be));
            check("sram_din", wr_din[base + k], exp_din);
            check("write cycle", 128'(wr_cycle[base + k]), 128'(first + k));
        end
    endtask

    task automatic test_reset();
        @(negedge clk);
        check("rdy", 128'(rdy), 128'(1));
        check("awvld", 128'(awvld), 128'(0));
        check("write strobes", 128'({iram_we, wram_we, oram_we}), 128'(0));
    endtask

    task automatic test_iram_single();
        int acc;
        int rc;
        int base;
        @(posedge clk);
        mxu_data_rdy <= 1'b1;
        base = wr_we.size();
        drive_cmd(4'b0001, 4'd7, 8'd1, 4'd0, 3'd4, 31'h0000_0a50, 3'd0);
        wait_accept(acc);
        drive_idle();
        wait_rdy(rc);
        check("write count", 128'(wr_we.size() - base), 128'(1));
        check_sram(3'b100, base, 4'd7, 8'd1, 4'd0, 3'd4, 12'ha50, acc + 2);
        check("rdy rise cycle", 128'(rc), 128'(acc + 3));
    endtask

    task automatic test_wram_wait();
        int acc;
        int rc;
        int base;
        int rise;
        @(posedge clk);
        mxu_data_rdy <= 1'b0;
        base = wr_we.size();
        drive_cmd(4'b0010, 4'd2, 8'd3, 4'd5, 3'd2, 31'h0000_03f0, 3'd0);
        wait_accept(acc);
        drive_idle();
        repeat (5) @(posedge clk);
        check("writes before mxu_data_rdy", 128'(wr_we.size() - base), 128'(0));
        mxu_data_rdy <= 1'b1;
        @(negedge clk);
        rise = cycle;
        wait_rdy(rc);
        check("write count", 128'(wr_we.size() - base), 128'(3));
        check_sram(3'b010, base, 4'd2, 8'd3, 4'd5, 3'd2, 12'h3f0, rise + 2);
        check("rdy rise cycle", 128'(rc), 128'(rise + 5));
    endtask

    task automatic test_oram_priority();
        int acc;
        int rc;
        int base;
        int aw0;
        @(posedge clk);
        base = wr_we.size();
        aw0  = aw_count;
        // oram wins over dram when both flags are set
        drive_cmd(4'b1100, 4'd10, 8'd3, 4'd8, 3'd3, 31'h0000_0120, 3'd0);
        wait_accept(acc);
        drive_idle();
        wait_rdy(rc);
        check("write count", 128'(wr_we.size() - base), 128'(3));
        check_sram(3'b001, base, 4'd10, 8'd3, 4'd8, 3'd3, 12'h120, acc + 2);
        check("awvld cycles", 128'(aw_count - aw0), 128'(0));
        check("rdy rise cycle", 128'(rc), 128'(acc + 5));
    endtask

    task automatic test_dram_backpressure();
        int          acc;
        int          rc;
        int          base;
        logic [31:0] da;
        @(posedge clk);
        awrdy <= 1'b0;
        da   = next_rand();
        base = wr_we.size();
        drive_cmd(4'b1000, 4'd0, 8'd12, 4'd0, 3'd2, da[30:0], 3'd5);
        wait_accept(acc);
        drive_idle();
        repeat (4) begin
            @(negedge clk);
            check("awvld", 128'(awvld), 128'(1));
            check("awaddr", 128'(awaddr), 128'(da[13:4]));
            check("awlen", 128'(awlen), 128'(12));
            check("awsize", 128'(awsize), 128'(2));
            check("awstr", 128'(awstr), 128'(5));
            check("awnum", 128'(awnum), 128'(16 / (1 << 2)));
            check("rdy", 128'(rdy), 128'(0));
        end
        @(posedge clk);
        awrdy <= 1'b1;
        @(posedge clk);
        awrdy <= 1'b0;
        @(negedge clk);
        check("awvld", 128'(awvld), 128'(0));
        check("rdy", 128'(rdy), 128'(0));
        wait_rdy(rc);
        check("rdy rise cycle", 128'(rc), 128'(acc + 6));
        check("write count", 128'(wr_we.size() - base), 128'(0));
    endtask

    task automatic test_back_to_back();
        int acc_a;
        int acc_b;
        int rc;
        int base;
        @(posedge clk);
        base = wr_we.size();
        drive_cmd(4'b0001, 4'd12, 8'd4, 4'd0, 3'd3, 31'h0000_0800, 3'd0);
        wait_accept(acc_a);
        // vld stays high, second command waits for rdy
        drive_cmd(4'b0010, 4'd1, 8'd2, 4'd14, 3'd1, 31'h0000_07e0, 3'd0);
        wait_accept(acc_b);
        drive_idle();
        check("second accept cycle", 128'(acc_b), 128'(acc_a + 7));
        wait_rdy(rc);
        check("write count", 128'(wr_we.size() - base), 128'(6));
        check_sram(3'b100, base, 4'd12, 8'd4, 4'd0, 3'd3, 12'h800, acc_a + 2);
        check_sram(3'b010, base + 4, 4'd1, 8'd2, 4'd14, 3'd1, 12'h7e0, acc_b + 2);
        check("rdy rise cycle", 128'(rc), 128'(acc_b + 4));
    endtask

    initial begin
        rst_n        <= 1'b0;
        mxu_data_rdy <= 1'b0;
        awrdy        <= 1'b0;
        drive_idle();
        drive_cmd(4'b0000, 4'd0, 8'd0, 4'd0, 3'd0, 31'd0, 3'd0);
        vld          <= 1'b0;
        fill_matrix();
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        test_reset();
        test_iram_single();
        test_wram_wait();
        test_oram_priority();
        test_dram_backpressure();
        test_back_to_back();
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
